// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_cci_trace
FILELIST  := cci_trace.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: cci_trace.f
+incdir+src
src/cci_pkg.sv
src/trace_pkg.sv
src/cci_event_classifier.sv
src/trace_serializer.sv
src/trace_buffer.sv
src/cci_trace_top.sv
test/tb_cci_trace.sv

// File: src/cci_event_classifier.sv
`timescale 1ns/1ps

`include "trace_params.svh"

module cci_event_classifier (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  trace_en,
   input  logic                  tx_c0_valid,
   input  cci_pkg::t_req_hdr     tx_c0_hdr,
   input  logic                  tx_c1_valid,
   input  cci_pkg::t_req_hdr     tx_c1_hdr,
   input  logic                  rx_c0_rsp_valid,
   input  logic                  rx_c0_mmio_wr_valid,
   input  logic                  rx_c0_mmio_rd_valid,
   input  cci_pkg::t_rx_c0_hdr   rx_c0_hdr,
   input  logic                  rx_c1_valid,
   input  cci_pkg::t_rsp_hdr     rx_c1_hdr,
   output logic [3:0]            lane_valid,
   output trace_pkg::t_trace_rec lane_rec [4]
);
   import cci_pkg::*;
   import trace_pkg::*;

   logic [`TRACE_TS_WIDTH-1:0] ts_q;
   logic [3:0]                 valid_d;
   t_trace_rec                 rec_d [4];

   // Free-running stamp, zero at the first edge out of reset
   always_ff @(posedge clk) begin
      if (reset) begin
         ts_q <= '0;
      end else begin
         ts_q <= ts_q + 1'b1;
      end
   end

   // Common request fields, kind filled in by the caller
   function automatic t_trace_rec req_fields(t_req_hdr hdr);
      t_trace_rec r;
      r      = '0;
      r.vc   = hdr.vc;
      r.tag  = hdr.mdata;
      r.addr = hdr.addr;
      r.len  = hdr.cl_len;
      return r;
   endfunction

   // Common response fields, no address
   function automatic t_trace_rec rsp_fields(t_rsp_hdr hdr);
      t_trace_rec r;
      r     = '0;
      r.vc  = hdr.vc_used;
      r.tag = hdr.mdata;
      r.len = hdr.cl_num;
      return r;
   endfunction

   ////////////////////////////////////////
   // Per-channel decode
   ////////////////////////////////////////

   always_comb begin
      // Lane 0, read requests
      rec_d[0] = req_fields(tx_c0_hdr);
      case (tx_c0_hdr.req_type)
         REQ_RDLINE_S: rec_d[0].kind = RD_REQ_S;
         REQ_RDLINE_I: rec_d[0].kind = RD_REQ_I;
         default:      rec_d[0].kind = BAD_TYPE;
      endcase

      // Lane 1, writes, fences, interrupts
      rec_d[1] = req_fields(tx_c1_hdr);
      case (tx_c1_hdr.req_type)
         REQ_WRLINE_I: rec_d[1].kind = WR_REQ_I;
         REQ_WRLINE_M: rec_d[1].kind = WR_REQ_M;
         REQ_WRFENCE:  rec_d[1].kind = WR_FENCE;
         REQ_INTR:     rec_d[1].kind = INTR_REQ;
         default:      rec_d[1].kind = BAD_TYPE;
      endcase

      // Lane 2, one word read as MMIO or as response
      rec_d[2] = '0;
      if (rx_c0_mmio_wr_valid || rx_c0_mmio_rd_valid) begin
         rec_d[2].vc   = VC_VA;
         rec_d[2].addr = rx_c0_hdr.mmio.addr;
         rec_d[2].len  = rx_c0_hdr.mmio.length;
         if (rx_c0_mmio_wr_valid) begin
            rec_d[2].kind = MMIO_WR;
         end else begin
            rec_d[2].kind = MMIO_RD;
            rec_d[2].tag  = {7'd0, rx_c0_hdr.mmio.tid};
         end
      end else begin
         rec_d[2] = rsp_fields(rx_c0_hdr.rsp);
         case (rx_c0_hdr.rsp.resp_type)
            RSP_RDLINE: rec_d[2].kind = RD_RSP;
            RSP_UMSG: begin
               // Hint flag in mdata[15], id in the low six bits
               rec_d[2].kind = rx_c0_hdr.rsp.mdata[15] ? UMSG_HINT : UMSG_DATA;
               rec_d[2].tag  = {10'd0, rx_c0_hdr.rsp.mdata[5:0]};
            end
            default:    rec_d[2].kind = BAD_TYPE;
         endcase
      end

      // Lane 3, write-side responses
      rec_d[3] = rsp_fields(rx_c1_hdr);
      case (rx_c1_hdr.resp_type)
         RSP_WRLINE:  rec_d[3].kind = WR_RSP;
         RSP_WRFENCE: rec_d[3].kind = FENCE_RSP;
         RSP_INTR:    rec_d[3].kind = INTR_RSP;
         default:     rec_d[3].kind = BAD_TYPE;
      endcase

      // Same stamp for every lane of this edge
      for (int i = 0; i < `TRACE_LANES; i++) begin
         rec_d[i].ts = ts_q;
      end
   end

   // Strobes gated by the enable level
   assign valid_d[0] = trace_en && tx_c0_valid;
   assign valid_d[1] = trace_en && tx_c1_valid;
   assign valid_d[2] = trace_en &&
                       (rx_c0_rsp_valid || rx_c0_mmio_wr_valid || rx_c0_mmio_rd_valid);
   assign valid_d[3] = trace_en && rx_c1_valid;

   // Output register stage
   always_ff @(posedge clk) begin
      if (reset) begin
         lane_valid <= '0;
      end else begin
         lane_valid <= valid_d;
      end
      lane_rec <= rec_d;
   end

   // Rx c0 word has one owner per cycle
   assert property (@(posedge clk) disable iff (reset)
      $onehot0({rx_c0_rsp_valid, rx_c0_mmio_wr_valid, rx_c0_mmio_rd_valid}));

endmodule

// File: src/cci_pkg.sv
package cci_pkg;

   ////////////////////////////////////////
   // Channel and code encodings
   ////////////////////////////////////////

   // Virtual channel select / used
   typedef enum logic [1:0] {
      VC_VA  = 2'd0,
      VC_VL0 = 2'd1,
      VC_VH0 = 2'd2,
      VC_VH1 = 2'd3
   } t_vc;

   // Read request codes on tx channel 0
   typedef enum logic [3:0] {
      REQ_RDLINE_I = 4'h0,
      REQ_RDLINE_S = 4'h1
   } t_c0_req;

   // Write, fence and interrupt requests on tx channel 1
   typedef enum logic [3:0] {
      REQ_WRLINE_I = 4'h0,
      REQ_WRLINE_M = 4'h1,
      REQ_WRFENCE  = 4'h4,
      REQ_INTR     = 4'h6
   } t_c1_req;

   // Responses on rx channel 0
   typedef enum logic [3:0] {
      RSP_RDLINE = 4'h0,
      RSP_UMSG   = 4'h4
   } t_c0_rsp;

   // Responses on rx channel 1
   typedef enum logic [3:0] {
      RSP_WRLINE  = 4'h0,
      RSP_WRFENCE = 4'h4,
      RSP_INTR    = 4'h8
   } t_c1_rsp;

   ////////////////////////////////////////
   // Headers
   ////////////////////////////////////////

   // Request header, type kept raw so bad codes survive
   typedef struct packed {
      t_vc         vc;
      logic [3:0]  req_type;
      logic [1:0]  cl_len;
      logic [15:0] addr;
      logic [15:0] mdata;
   } t_req_hdr;

   // Response header
   // UMsg reuses mdata: bit 15 hint, bits 5..0 id
   typedef struct packed {
      t_vc         vc_used;
      logic [3:0]  resp_type;
      logic [1:0]  cl_num;
      logic [15:0] mdata;
      logic [3:0]  rsvd;
   } t_rsp_hdr;

   // MMIO request header, length code 0/1/2 for 4/8/64 bytes
   typedef struct packed {
      logic [15:0] addr;
      logic [1:0]  length;
      logic [8:0]  tid;
      logic        rsvd;
   } t_mmio_hdr;

   // Rx channel 0 word, view picked by the active strobe
   typedef union packed {
      t_rsp_hdr  rsp;
      t_mmio_hdr mmio;
   } t_rx_c0_hdr;

endpackage

// File: src/cci_trace_top.sv
`timescale 1ns/1ps

`include "trace_params.svh"

module cci_trace_top (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         trace_en,
   input  logic                         tx_c0_valid,
   input  cci_pkg::t_req_hdr            tx_c0_hdr,
   input  logic                         tx_c1_valid,
   input  cci_pkg::t_req_hdr            tx_c1_hdr,
   input  logic                         rx_c0_rsp_valid,
   input  logic                         rx_c0_mmio_wr_valid,
   input  logic                         rx_c0_mmio_rd_valid,
   input  cci_pkg::t_rx_c0_hdr          rx_c0_hdr,
   input  logic                         rx_c1_valid,
   input  cci_pkg::t_rsp_hdr            rx_c1_hdr,
   input  logic                         rd_en,
   output trace_pkg::t_trace_rec        rd_record,
   output logic                         rd_empty,
   output logic [`TRACE_DROP_WIDTH-1:0] drop_count
);
   import trace_pkg::*;

   // Classifier to serializer, one pulse per lane
   logic [3:0] lane_valid;
   t_trace_rec lane_rec [4];

   // Serializer to buffer
   logic       buf_wr;
   t_trace_rec buf_rec;
   logic       buf_full;

   cci_event_classifier u_classifier (
      .clk                 (clk),
      .reset               (reset),
      .trace_en            (trace_en),
      .tx_c0_valid         (tx_c0_valid),
      .tx_c0_hdr           (tx_c0_hdr),
      .tx_c1_valid         (tx_c1_valid),
      .tx_c1_hdr           (tx_c1_hdr),
      .rx_c0_rsp_valid     (rx_c0_rsp_valid),
      .rx_c0_mmio_wr_valid (rx_c0_mmio_wr_valid),
      .rx_c0_mmio_rd_valid (rx_c0_mmio_rd_valid),
      .rx_c0_hdr           (rx_c0_hdr),
      .rx_c1_valid         (rx_c1_valid),
      .rx_c1_hdr           (rx_c1_hdr),
      .lane_valid          (lane_valid),
      .lane_rec            (lane_rec)
   );

   trace_serializer u_serializer (
      .clk        (clk),
      .reset      (reset),
      .lane_valid (lane_valid),
      .lane_rec   (lane_rec),
      .buf_full   (buf_full),
      .buf_wr     (buf_wr),
      .buf_rec    (buf_rec),
      .drop_count (drop_count)
   );

   trace_buffer #(
      .DEPTH (`TRACE_DEPTH)
   ) u_buffer (
      .clk       (clk),
      .reset     (reset),
      .wr        (buf_wr),
      .wr_rec    (buf_rec),
      .full      (buf_full),
      .rd_en     (rd_en),
      .rd_record (rd_record),
      .empty     (rd_empty)
   );

endmodule

// File: src/trace_buffer.sv
`timescale 1ns/1ps

`include "trace_params.svh"

module trace_buffer #(
   parameter int DEPTH = `TRACE_DEPTH
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  wr,
   input  trace_pkg::t_trace_rec wr_rec,
   output logic                  full,
   input  logic                  rd_en,
   output trace_pkg::t_trace_rec rd_record,
   output logic                  empty
);
   import trace_pkg::*;

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   t_trace_rec    mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          do_wr;
   logic          do_rd;

   assign full  = (count == CW'(DEPTH));
   assign empty = (count == '0);

   // Requests outside the legal window are ignored
   assign do_wr = wr && !full;
   assign do_rd = rd_en && !empty;

   // Head is visible with no read strobe
   assign rd_record = mem[rd_ptr];

   ////////////////////////////////////////
   // Pointers and occupancy
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            // Wrap explicitly for depths off a power of two
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Record store
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_rec;
      end
   end

   // Occupancy bounded by the array
   assert property (@(posedge clk) disable iff (reset) count <= CW'(DEPTH));

endmodule

// File: src/trace_params.svh
`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

// Records held in the on-chip trace store
`define TRACE_DEPTH 16

// Cycle stamp width, wraps silently
`define TRACE_TS_WIDTH 24

// Drop counter width, saturates at all ones
`define TRACE_DROP_WIDTH 16

// Lanes traced: tx_c0, tx_c1, rx_c0, rx_c1
`define TRACE_LANES 4

`endif

// File: src/trace_pkg.sv
`include "trace_params.svh"

package trace_pkg;

   ////////////////////////////////////////
   // Event kinds
   ////////////////////////////////////////

   typedef enum logic [3:0] {
      RD_REQ_S  = 4'd0,
      RD_REQ_I  = 4'd1,
      WR_REQ_I  = 4'd2,
      WR_REQ_M  = 4'd3,
      WR_FENCE  = 4'd4,
      INTR_REQ  = 4'd5,
      RD_RSP    = 4'd6,
      UMSG_HINT = 4'd7,
      UMSG_DATA = 4'd8,
      MMIO_WR   = 4'd9,
      MMIO_RD   = 4'd10,
      WR_RSP    = 4'd11,
      FENCE_RSP = 4'd12,
      INTR_RSP  = 4'd13,
      // Any code the channel does not define
      BAD_TYPE  = 4'd14
   } t_event_kind;

   ////////////////////////////////////////
   // Trace record
   ////////////////////////////////////////

   // Tag: mdata, MMIO tid, or UMsg id
   // Addr is zero for responses
   typedef struct packed {
      logic [`TRACE_TS_WIDTH-1:0] ts;
      t_event_kind                kind;
      cci_pkg::t_vc               vc;
      logic [15:0]                tag;
      logic [15:0]                addr;
      logic [1:0]                 len;
   } t_trace_rec;

endpackage

// File: src/trace_serializer.sv
`timescale 1ns/1ps

`include "trace_params.svh"

module trace_serializer (
   input  logic                         clk,
   input  logic                         reset,
   input  logic [3:0]                   lane_valid,
   input  trace_pkg::t_trace_rec        lane_rec [4],
   input  logic                         buf_full,
   output logic                         buf_wr,
   output trace_pkg::t_trace_rec        buf_rec,
   output logic [`TRACE_DROP_WIDTH-1:0] drop_count
);
   import trace_pkg::*;

   localparam int TS_W = `TRACE_TS_WIDTH;
   localparam int DW   = `TRACE_DROP_WIDTH;

   logic [TS_W-1:0] now_q;
   logic [3:0]      slot_valid;
   t_trace_rec      slot_rec [4];
   logic [TS_W-1:0] age [4];
   logic            sel_found;
   logic [1:0]      sel_idx;
   logic [TS_W-1:0] sel_age;
   logic [3:0]      clr;
   logic [3:0]      busy;
   logic [3:0]      drop;
   logic [2:0]      n_drop;
   logic [DW:0]     drop_sum;

   // Local cycle count, in step with the classifier stamp
   always_ff @(posedge clk) begin
      if (reset) begin
         now_q <= '0;
      end else begin
         now_q <= now_q + 1'b1;
      end
   end

   ////////////////////////////////////////
   // Oldest-first pick
   ////////////////////////////////////////

   always_comb begin
      sel_found = 1'b0;
      sel_idx   = '0;
      sel_age   = '0;
      for (int i = 0; i < `TRACE_LANES; i++) begin
         // Modular distance, immune to stamp wrap
         age[i] = now_q - slot_rec[i].ts;
         // Strict compare keeps ties on the lower lane
         if (slot_valid[i] && (!sel_found || age[i] > sel_age)) begin
            sel_found = 1'b1;
            sel_idx   = 2'(i);
            sel_age   = age[i];
         end
      end
   end

   assign buf_wr  = sel_found && !buf_full;
   assign buf_rec = slot_rec[sel_idx];

   // Slot release, occupancy and drop detection
   always_comb begin
      n_drop = '0;
      for (int i = 0; i < `TRACE_LANES; i++) begin
         clr[i]  = buf_wr && (sel_idx == 2'(i));
         busy[i] = slot_valid[i] && !clr[i];
         drop[i] = lane_valid[i] && busy[i];
         n_drop  = n_drop + 3'(drop[i]);
      end
      drop_sum = {1'b0, drop_count} + (DW+1)'(n_drop);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         slot_valid <= '0;
         drop_count <= '0;
      end else begin
         for (int i = 0; i < `TRACE_LANES; i++) begin
            if (lane_valid[i] && !busy[i]) begin
               slot_valid[i] <= 1'b1;
            end else if (clr[i]) begin
               slot_valid[i] <= 1'b0;
            end
         end
         // Saturate instead of wrapping
         drop_count <= drop_sum[DW] ? '1 : drop_sum[DW-1:0];
      end
      for (int i = 0; i < `TRACE_LANES; i++) begin
         if (lane_valid[i] && !busy[i]) begin
            slot_rec[i] <= lane_rec[i];
         end
      end
   end

   // Full level parks every pending record in its slot
   assert property (@(posedge clk) disable iff (reset)
      buf_full |=> &(slot_valid | ~$past(slot_valid)));

   // Drop count only moves up between resets
   assert property (@(posedge clk) disable iff (reset)
      !$past(reset) |-> drop_count >= $past(drop_count));

endmodule

// File: test/tb_cci_trace.sv
`timescale 1ns/1ps

`include "trace_params.svh"

module tb_cci_trace;
   import cci_pkg::*;
   import trace_pkg::*;

   localparam int DW        = `TRACE_DROP_WIDTH;
   localparam int DEPTH     = `TRACE_DEPTH;
   localparam int N_SPARSE  = 240;
   localparam int N_DENSE   = 200;
   localparam int N_OFF     = 40;
   localparam int N_HOLD    = 2 * (DEPTH + 8);
   localparam int DRAIN_MAX = 2 * DEPTH + 12;
   // Reset, all phases, worst-case drains, then depth and margin
   localparam int CYCLE_LIMIT = 3 + N_SPARSE + N_DENSE + N_OFF + N_HOLD
                                + 4 * DRAIN_MAX + DEPTH + 20;

   logic                       clk;
   logic                       reset;
   logic                       trace_en;
   logic                       tx_c0_valid;
   t_req_hdr                   tx_c0_hdr;
   logic                       tx_c1_valid;
   t_req_hdr                   tx_c1_hdr;
   logic                       rx_c0_rsp_valid;
   logic                       rx_c0_mmio_wr_valid;
   logic                       rx_c0_mmio_rd_valid;
   t_rx_c0_hdr                 rx_c0_hdr;
   logic                       rx_c1_valid;
   t_rsp_hdr                   rx_c1_hdr;
   logic                       rd_en;
   t_trace_rec                 rd_record;
   logic                       rd_empty;
   logic [DW-1:0]              drop_count;

   // Model state
   logic [31:0]                lcg_state;
   logic [`TRACE_TS_WIDTH-1:0] tb_ts;
   t_trace_rec                 exp_q [$];
   logic [DW-1:0]              skip_count;
   int                         exact_pops;
   int                         pop_count;
   int                         cycle_count;

   cci_trace_top dut (
      .clk                 (clk),
      .reset               (reset),
      .trace_en            (trace_en),
      .tx_c0_valid         (tx_c0_valid),
      .tx_c0_hdr           (tx_c0_hdr),
      .tx_c1_valid         (tx_c1_valid),
      .tx_c1_hdr           (tx_c1_hdr),
      .rx_c0_rsp_valid     (rx_c0_rsp_valid),
      .rx_c0_mmio_wr_valid (rx_c0_mmio_wr_valid),
      .rx_c0_mmio_rd_valid (rx_c0_mmio_rd_valid),
      .rx_c0_hdr           (rx_c0_hdr),
      .rx_c1_valid         (rx_c1_valid),
      .rx_c1_hdr           (rx_c1_hdr),
      .rd_en               (rd_en),
      .rd_record           (rd_record),
      .rd_empty            (rd_empty),
      .drop_count          (drop_count)
   );

   always #10 clk = ~clk;

   task automatic stop_with_failure(input string why);
      $display("Test failures found");
      $fatal(1, "%s", why);
   endtask

   // Run limit
   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > CYCLE_LIMIT) begin
         stop_with_failure($sformatf("Run exceeded its limit of %0d cycles", CYCLE_LIMIT));
      end
   end

   ////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////

   task automatic check_record(input string name, input t_trace_rec got, input t_trace_rec want);
      if (got !== want) begin
         $display("[ERROR] %s got 0x%h expected 0x%h", name, got, want);
         stop_with_failure("Trace record differs from the model");
      end
   endtask

   task automatic check_count(input logic [DW-1:0] got, input logic [DW-1:0] want);
      if (got !== want) begin
         $display("[ERROR] drop_count got 0x%h expected 0x%h", got, want);
         stop_with_failure("Drop counter differs from the model");
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic want);
      if (got !== want) begin
         $display("[ERROR] %s got 0x%h expected 0x%h", name, got, want);
         stop_with_failure("Status flag differs from the model");
      end
   endtask

   ////////////////////////////////////////
   // Random stimulus
   ////////////////////////////////////////

   function automatic logic [31:0] lcg_step();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Upper halves only, low LCG bits repeat too soon
   function automatic logic [31:0] rand_word();
      logic [31:0] a;
      logic [31:0] b;
      a = lcg_step();
      b = lcg_step();
      return {a[31:16], b[31:16]};
   endfunction

   // Legal code most of the time, one in sixteen any nibble
   function automatic logic [3:0] pick_code(input logic [15:0] legal, input int n);
      logic [31:0] r;
      logic [15:0] sel;
      r = rand_word();
      if (r[3:0] == 4'd0) begin
         return r[7:4];
      end
      sel = legal >> (4 * (int'(r[15:8]) % n));
      return sel[3:0];
   endfunction

   function automatic t_req_hdr make_req_hdr(input logic [3:0] code);
      t_req_hdr    h;
      logic [31:0] r;
      logic [31:0] s;
      r = rand_word();
      s = rand_word();
      h.vc       = t_vc'(r[1:0]);
      h.req_type = code;
      h.cl_len   = r[3:2];
      h.addr     = r[31:16];
      h.mdata    = s[15:0];
      return h;
   endfunction

   function automatic t_rsp_hdr make_rsp_hdr(input logic [3:0] code);
      t_rsp_hdr    h;
      logic [31:0] r;
      r = rand_word();
      h.vc_used   = t_vc'(r[1:0]);
      h.resp_type = code;
      h.cl_num    = r[3:2];
      h.mdata     = r[31:16];
      h.rsvd      = r[7:4];
      return h;
   endfunction

   ////////////////////////////////////////
   // Decode model
   ////////////////////////////////////////

   // Requests: tag mdata, addr and cl_len as sent
   function automatic t_trace_rec decode_req(input int lane, input t_req_hdr h);
      t_trace_rec e;
      e      = '0;
      e.ts   = tb_ts;
      e.vc   = h.vc;
      e.tag  = h.mdata;
      e.addr = h.addr;
      e.len  = h.cl_len;
      e.kind = BAD_TYPE;
      if (lane == 0) begin
         case (h.req_type)
            REQ_RDLINE_S: e.kind = RD_REQ_S;
            REQ_RDLINE_I: e.kind = RD_REQ_I;
            default:      e.kind = BAD_TYPE;
         endcase
      end else begin
         case (h.req_type)
            REQ_WRLINE_I: e.kind = WR_REQ_I;
            REQ_WRLINE_M: e.kind = WR_REQ_M;
            REQ_WRFENCE:  e.kind = WR_FENCE;
            REQ_INTR:     e.kind = INTR_REQ;
            default:      e.kind = BAD_TYPE;
         endcase
      end
      return e;
   endfunction

   // Responses: no address, UMsg tag is the six-bit id
   function automatic t_trace_rec decode_rsp(input int lane, input t_rsp_hdr h);
      t_trace_rec e;
      e      = '0;
      e.ts   = tb_ts;
      e.vc   = h.vc_used;
      e.tag  = h.mdata;
      e.len  = h.cl_num;
      e.kind = BAD_TYPE;
      if (lane == 2) begin
         case (h.resp_type)
            RSP_RDLINE: e.kind = RD_RSP;
            RSP_UMSG: begin
               e.kind = h.mdata[15] ? UMSG_HINT : UMSG_DATA;
               e.tag  = {10'd0, h.mdata[5:0]};
            end
            default:    e.kind = BAD_TYPE;
         endcase
      end else begin
         case (h.resp_type)
            RSP_WRLINE:  e.kind = WR_RSP;
            RSP_WRFENCE: e.kind = FENCE_RSP;
            RSP_INTR:    e.kind = INTR_RSP;
            default:     e.kind = BAD_TYPE;
         endcase
      end
      return e;
   endfunction

   // MMIO view of the rx c0 word, tid only on reads
   function automatic t_trace_rec decode_mmio(input logic is_rd, input t_mmio_hdr m);
      t_trace_rec e;
      e      = '0;
      e.ts   = tb_ts;
      e.vc   = VC_VA;
      e.addr = m.addr;
      e.len  = m.length;
      e.kind = is_rd ? MMIO_RD : MMIO_WR;
      e.tag  = is_rd ? {7'd0, m.tid} : 16'd0;
      return e;
   endfunction

   ////////////////////////////////////////
   // Drive and observe
   ////////////////////////////////////////

   task automatic clear_strobes();
      tx_c0_valid         = 1'b0;
      tx_c1_valid         = 1'b0;
      rx_c0_rsp_valid     = 1'b0;
      rx_c0_mmio_wr_valid = 1'b0;
      rx_c0_mmio_rd_valid = 1'b0;
      rx_c1_valid         = 1'b0;
   endtask

   task automatic drive_lane(input int lane);
      logic [31:0] r;
      r = rand_word();
      case (lane)
         0: begin
            tx_c0_valid = 1'b1;
            tx_c0_hdr   = make_req_hdr(pick_code({8'h00, REQ_RDLINE_S, REQ_RDLINE_I}, 2));
         end
         1: begin
            tx_c1_valid = 1'b1;
            tx_c1_hdr   = make_req_hdr(pick_code({REQ_INTR, REQ_WRFENCE,
                                                  REQ_WRLINE_M, REQ_WRLINE_I}, 4));
         end
         2: begin
            // One strobe picks the reading of the shared word
            rx_c0_hdr = t_rx_c0_hdr'(r[27:0]);
            if (r[31:30] == 2'd0) begin
               rx_c0_mmio_wr_valid = 1'b1;
            end else if (r[31:30] == 2'd1) begin
               rx_c0_mmio_rd_valid = 1'b1;
            end else begin
               rx_c0_rsp_valid = 1'b1;
               rx_c0_hdr.rsp   = make_rsp_hdr(pick_code({8'h00, RSP_UMSG, RSP_RDLINE}, 2));
            end
         end
         default: begin
            rx_c1_valid = 1'b1;
            rx_c1_hdr   = make_rsp_hdr(pick_code({4'h0, RSP_INTR, RSP_WRFENCE, RSP_WRLINE}, 3));
         end
      endcase
   endtask

   // Queue in lane order what the coming edge samples
   task automatic expect_sampled();
      if (trace_en) begin
         if (tx_c0_valid) begin
            exp_q.push_back(decode_req(0, tx_c0_hdr));
         end
         if (tx_c1_valid) begin
            exp_q.push_back(decode_req(1, tx_c1_hdr));
         end
         if (rx_c0_mmio_wr_valid || rx_c0_mmio_rd_valid) begin
            exp_q.push_back(decode_mmio(rx_c0_mmio_rd_valid, rx_c0_hdr.mmio));
         end else if (rx_c0_rsp_valid) begin
            exp_q.push_back(decode_rsp(2, rx_c0_hdr.rsp));
         end
         if (rx_c1_valid) begin
            exp_q.push_back(decode_rsp(3, rx_c1_hdr));
         end
      end
      tb_ts = tb_ts + 1'b1;
   endtask

   // Head record leaves at the coming edge when rd_en is set
   task automatic match_popped();
      t_trace_rec got;
      t_trace_rec want;
      if (!rd_en || rd_empty) begin
         return;
      end
      got = rd_record;
      pop_count++;
      if (exp_q.size() == 0) begin
         $display("[ERROR] rd_record 0x%h popped with nothing expected", got);
         stop_with_failure("Record left the buffer with no traced event behind it");
      end
      if (exact_pops > 0) begin
         exact_pops--;
         want = exp_q.pop_front();
         check_record("rd_record", got, want);
      end else begin
         // Every passed-over entry is one dropped event
         while (exp_q.size() != 0 && exp_q[0] !== got) begin
            want       = exp_q.pop_front();
            skip_count = skip_count + 1'b1;
         end
         if (exp_q.size() == 0) begin
            $display("[ERROR] rd_record 0x%h matches no expected record", got);
            stop_with_failure("Record out of order or not in the model");
         end
         want = exp_q.pop_front();
      end
   endtask

   task automatic advance_cycle();
      match_popped();
      expect_sampled();
      @(negedge clk);
   endtask

   // Read until the buffer has stayed empty a while
   task automatic drain_trace();
      int quiet;
      quiet = 0;
      clear_strobes();
      rd_en = 1'b1;
      while (quiet < 6) begin
         if (rd_empty) begin
            quiet++;
         end else begin
            quiet = 0;
         end
         advance_cycle();
      end
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      logic [31:0]   r;
      logic [DW-1:0] held;
      logic [3:0]    parked;
      int            lane;
      int            n_events;
      int            want_pops;
      clk         = 1'b0;
      reset       = 1'b1;
      trace_en    = 1'b0;
      rd_en       = 1'b0;
      tx_c0_hdr   = '0;
      tx_c1_hdr   = '0;
      rx_c0_hdr   = '0;
      rx_c1_hdr   = '0;
      clear_strobes();
      lcg_state   = 32'd19005;
      tb_ts       = '0;
      skip_count  = '0;
      exact_pops  = 0;
      pop_count   = 0;
      cycle_count = 0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // Reset state
      check_flag("rd_empty", rd_empty, 1'b1);
      check_count(drop_count, '0);

      // Sparse traffic, one strobe every other cycle, no skips allowed
      trace_en   = 1'b1;
      rd_en      = 1'b1;
      exact_pops = N_SPARSE;
      for (int i = 0; i < N_SPARSE; i++) begin
         clear_strobes();
         if (i % 2 == 0) begin
            drive_lane(int'(rand_word() % 32'd4));
         end
         advance_cycle();
      end
      drain_trace();
      if (exp_q.size() != 0) begin
         stop_with_failure("Sparse events never reached the readout");
      end
      check_count(drop_count, '0);

      // Dense bursts on all lanes with random reads
      exact_pops = 0;
      for (int i = 0; i < N_DENSE; i++) begin
         r = rand_word();
         clear_strobes();
         for (int lane = 0; lane < 4; lane++) begin
            if (r[lane*4 +: 4] < 4'd12) begin
               drive_lane(lane);
            end
         end
         rd_en = (r[19:18] != 2'd0);
         advance_cycle();
      end
      drain_trace();
      // Tail entries never read out were dropped too
      skip_count = skip_count + DW'(exp_q.size());
      exp_q.delete();
      check_count(drop_count, skip_count);
      if (drop_count == '0) begin
         stop_with_failure("Dense bursts produced no drops");
      end

      // Tracing off, strobes ignored
      trace_en = 1'b0;
      held     = drop_count;
      for (int i = 0; i < N_OFF; i++) begin
         r = rand_word();
         clear_strobes();
         for (int lane = 0; lane < 4; lane++) begin
            if (r[lane]) begin
               drive_lane(lane);
            end
         end
         advance_cycle();
         check_flag("rd_empty", rd_empty, 1'b1);
         check_count(drop_count, held);
      end

      // Back-pressure, reads held off past the buffer depth
      trace_en   = 1'b1;
      rd_en      = 1'b0;
      exact_pops = DEPTH;
      parked     = '0;
      n_events   = 0;
      for (int i = 0; i < N_HOLD; i++) begin
         clear_strobes();
         if (i % 2 == 0) begin
            lane = int'(rand_word() % 32'd4);
            // Past the depth, the first event per lane waits in its slot
            if (n_events >= DEPTH) begin
               parked[lane] = 1'b1;
            end
            n_events++;
            drive_lane(lane);
         end
         advance_cycle();
      end
      check_flag("rd_empty", rd_empty, 1'b0);
      pop_count = 0;
      drain_trace();
      // Full buffer plus one parked record per lane with late traffic
      want_pops = DEPTH + $countones(parked);
      if (pop_count != want_pops) begin
         stop_with_failure($sformatf("Back-pressure drained %0d records, expected %0d",
                                     pop_count, want_pops));
      end
      check_count(drop_count, held + DW'(n_events - want_pops));
      skip_count = skip_count + DW'(exp_q.size());
      exp_q.delete();

      // Every traced event read out or counted as dropped
      if (drop_count === skip_count) begin
         $display("All tests passed!");
         $finish;
      end else begin
         $display("[ERROR] drop_count 0x%h model skips 0x%h", drop_count, skip_count);
         stop_with_failure("Trace does not account for every event");
      end
   end

endmodule
